// ==== hw/bridge_pkg.sv ====
package bridge_pkg;

	localparam int HOST_W = 16;
	localparam int CORE_W = 32;
	localparam int ADDR_W = 16;

	typedef logic [HOST_W-1:0] host_word_t;
	typedef logic [CORE_W-1:0] core_word_t;

	// Frame codes on the host FIFO
	localparam host_word_t FRAME_SYNC = 16'hFFF0;
	localparam host_word_t CMD_WRITE = 16'hFFF1;
	localparam host_word_t CMD_READ = 16'hFFF2;
	localparam host_word_t CMD_START = 16'hFFF3;

	// Byte count advance per halfword moved
	localparam int BYTES_PER_HALF = 2;

	typedef enum logic [4:0] {
		st_idle,
		st_settle,
		st_pop,
		st_pop_wait,
		st_sync,
		st_id,
		st_stall,
		st_type,
		st_addr,
		st_size,
		st_next,
		st_wr_hi,
		st_wr_lo,
		st_rd_wait,
		st_rd_hi,
		st_rd_lo,
		st_reset,
		st_start,
		st_clean
	} seq_state_t;

endpackage

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int SETTLE_CYCLES = 20,
	parameter int READ_WAIT_CYCLES = 5,
	parameter int START_HOLD_CYCLES = 30,
	parameter int NUM_CORES = 8
) (
	input  logic                   SDK_CLK,
	input  logic                   SDK_RSTN,
	input  bridge_pkg::host_word_t fifo_di_i,
	input  logic                   fifo_empty_i,
	input  logic                   fifo_full_i,
	input  bridge_pkg::core_word_t ram_rdata_i,
	input  bridge_pkg::host_word_t core_id_i,
	input  logic                   more_data_i,
	input  logic                   sel_stalled_i,
	output logic                   fifo_rd_o,
	output logic                   fifo_wr_o,
	output bridge_pkg::host_word_t fifo_do_o,
	output logic                   latch_id_o,
	output logic                   latch_addr_o,
	output logic                   latch_size_o,
	output logic                   latch_hi_o,
	output logic                   latch_lo_o,
	output logic                   count_step_o,
	output logic                   clear_o,
	output logic                   ram_write_o,
	output logic                   core_reset_o,
	output logic                   core_start_o
);
	import bridge_pkg::*;

	seq_state_t state_q, state_d;
	// State to resume in once a popped word is on fifo_di_i
	seq_state_t ret_q, ret_d;
	host_word_t type_q, type_d;
	host_word_t do_d;
	logic rd_d;
	logic wr_d;
	logic delay_en;
	logic [15:0] delay_cnt;

	always_comb begin
		state_d = state_q;
		ret_d = ret_q;
		type_d = type_q;
		rd_d = 1'b0;
		wr_d = 1'b0;
		do_d = '0;
		delay_en = 1'b0;
		latch_id_o = 1'b0;
		latch_addr_o = 1'b0;
		latch_size_o = 1'b0;
		latch_hi_o = 1'b0;
		latch_lo_o = 1'b0;
		count_step_o = 1'b0;
		clear_o = 1'b0;
		ram_write_o = 1'b0;
		core_reset_o = 1'b0;
		core_start_o = 1'b0;
		case (state_q)
			st_idle: begin
				if (!fifo_empty_i) begin
					state_d = st_settle;
				end
			end
			st_settle: begin
				// Let the host finish filling the frame
				delay_en = 1'b1;
				if (delay_cnt == 16'(SETTLE_CYCLES - 1)) begin
					rd_d = 1'b1;
					ret_d = st_sync;
					state_d = st_pop_wait;
				end
			end
			st_pop: begin
				if (!fifo_empty_i) begin
					rd_d = 1'b1;
					state_d = st_pop_wait;
				end
			end
			st_pop_wait: begin
				state_d = ret_q;
			end
			st_sync: begin
				if (fifo_di_i == FRAME_SYNC) begin
					ret_d = st_id;
					state_d = st_pop;
				end else begin
					state_d = st_idle;
				end
			end
			st_id: begin
				latch_id_o = 1'b1;
				state_d = st_stall;
			end
			st_stall: begin
				// Unknown core, drop the rest of the frame
				if (core_id_i >= HOST_W'(NUM_CORES)) begin
					state_d = st_clean;
				end else if (sel_stalled_i) begin
					ret_d = st_type;
					state_d = st_pop;
				end
			end
			st_type: begin
				type_d = fifo_di_i;
				case (fifo_di_i)
					CMD_WRITE, CMD_READ: begin
						ret_d = st_addr;
						state_d = st_pop;
					end
					CMD_START: state_d = st_reset;
					default: state_d = st_clean;
				endcase
			end
			st_addr: begin
				latch_addr_o = 1'b1;
				ret_d = st_size;
				state_d = st_pop;
			end
			st_size: begin
				latch_size_o = 1'b1;
				state_d = st_next;
			end
			st_next: begin
				if (!more_data_i) begin
					state_d = st_clean;
				end else if (type_q == CMD_WRITE) begin
					ret_d = st_wr_hi;
					state_d = st_pop;
				end else begin
					state_d = st_rd_wait;
				end
			end
			st_wr_hi: begin
				latch_hi_o = 1'b1;
				count_step_o = 1'b1;
				ret_d = st_wr_lo;
				state_d = st_pop;
			end
			st_wr_lo: begin
				latch_lo_o = 1'b1;
				count_step_o = 1'b1;
				ram_write_o = 1'b1;
				state_d = st_next;
			end
			st_rd_wait: begin
				delay_en = 1'b1;
				if (delay_cnt == 16'(READ_WAIT_CYCLES - 1)) begin
					state_d = st_rd_hi;
				end
			end
			st_rd_hi: begin
				if (!fifo_full_i) begin
					wr_d = 1'b1;
					do_d = ram_rdata_i[CORE_W-1:HOST_W];
					count_step_o = 1'b1;
					state_d = st_rd_lo;
				end
			end
			st_rd_lo: begin
				if (!fifo_full_i) begin
					wr_d = 1'b1;
					do_d = ram_rdata_i[HOST_W-1:0];
					count_step_o = 1'b1;
					state_d = st_next;
				end
			end
			st_reset: begin
				core_reset_o = 1'b1;
				state_d = st_start;
			end
			st_start: begin
				delay_en = 1'b1;
				core_start_o = (delay_cnt == '0);
				if (delay_cnt == 16'(START_HOLD_CYCLES - 1)) begin
					state_d = st_clean;
				end
			end
			st_clean: begin
				clear_o = 1'b1;
				state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			state_q <= st_idle;
			ret_q <= st_idle;
			type_q <= '0;
			fifo_rd_o <= 1'b0;
			fifo_wr_o <= 1'b0;
		end else begin
			state_q <= state_d;
			ret_q <= ret_d;
			type_q <= type_d;
			fifo_rd_o <= rd_d;
			fifo_wr_o <= wr_d;
		end
	end

	always_ff @(posedge SDK_CLK) begin
		fifo_do_o <= do_d;
	end

	// Shared by settle, read wait and start hold
	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			delay_cnt <= '0;
		end else if (delay_en) begin
			delay_cnt <= delay_cnt + 16'd1;
		end else begin
			delay_cnt <= '0;
		end
	end

endmodule

// ==== hw/frame_fields.sv ====
`timescale 1ns/1ps

module frame_fields (
	input  logic                          SDK_CLK,
	input  logic                          SDK_RSTN,
	input  bridge_pkg::host_word_t        fifo_di_i,
	input  logic                          latch_id_i,
	input  logic                          latch_addr_i,
	input  logic                          latch_size_i,
	input  logic                          latch_hi_i,
	input  logic                          latch_lo_i,
	input  logic                          count_step_i,
	input  logic                          clear_i,
	output bridge_pkg::host_word_t        core_id_o,
	output logic [bridge_pkg::ADDR_W-1:0] word_index_o,
	output bridge_pkg::core_word_t        ram_wdata_o,
	output logic                          more_data_o
);
	import bridge_pkg::*;

	host_word_t id_q;
	logic [ADDR_W-1:0] base_q;
	host_word_t size_q;
	host_word_t byte_cnt;
	host_word_t hi_q;
	host_word_t lo_q;

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			id_q <= '0;
			base_q <= '0;
			size_q <= '0;
		end else begin
			if (latch_id_i) id_q <= fifo_di_i;
			if (latch_addr_i) base_q <= fifo_di_i;
			if (latch_size_i) size_q <= fifo_di_i;
		end
	end

	// Bytes moved so far in this frame
	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			byte_cnt <= '0;
		end else if (clear_i) begin
			byte_cnt <= '0;
		end else if (count_step_i) begin
			byte_cnt <= byte_cnt + HOST_W'(BYTES_PER_HALF);
		end
	end

	always_ff @(posedge SDK_CLK) begin
		if (latch_hi_i) hi_q <= fifo_di_i;
		if (latch_lo_i) lo_q <= fifo_di_i;
	end

	assign core_id_o = id_q;
	assign more_data_o = (byte_cnt < size_q);
	assign word_index_o = base_q + ADDR_W'(byte_cnt >> 2);
	// First halfword of a pair goes high
	assign ram_wdata_o = {hi_q, lo_q};

endmodule

// ==== hw/core_control.sv ====
`timescale 1ns/1ps

module core_control #(
	parameter int NUM_CORES = 8,
	parameter bridge_pkg::core_word_t HALT_PC = '0
) (
	input  logic                                   SDK_CLK,
	input  logic                                   SDK_RSTN,
	input  bridge_pkg::core_word_t [NUM_CORES-1:0] core_pc_i,
	input  bridge_pkg::host_word_t                 core_id_i,
	input  logic [bridge_pkg::ADDR_W-1:0]          word_index_i,
	input  logic                                   ram_write_i,
	input  logic                                   core_reset_i,
	input  logic                                   core_start_i,
	output logic [NUM_CORES-1:0]                   core_stall_o,
	output logic [NUM_CORES-1:0]                   core_rstn_o,
	output logic [NUM_CORES-1:0]                   ram_we_o,
	output logic [bridge_pkg::ADDR_W-1:0]          ram_addr_o,
	output logic                                   sel_stalled_o
);
	import bridge_pkg::*;

	logic [NUM_CORES-1:0] sel;
	logic [NUM_CORES-1:0] halted;
	logic [NUM_CORES-1:0] start_mask;

	// One-hot core select, all zero for an id out of range
	always_comb begin
		for (int i = 0; i < NUM_CORES; i++) begin
			sel[i] = (core_id_i == HOST_W'(i));
			halted[i] = (core_pc_i[i] == HALT_PC);
		end
	end

	assign start_mask = sel & {NUM_CORES{core_start_i}};

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			core_stall_o <= '1;
			core_rstn_o <= '1;
			ram_we_o <= '0;
		end else begin
			// Start wins over a halt seen in the same cycle
			core_stall_o <= (core_stall_o | halted) & ~start_mask;
			core_rstn_o <= ~(sel & {NUM_CORES{core_reset_i}});
			ram_we_o <= sel & {NUM_CORES{ram_write_i}};
		end
	end

	always_ff @(posedge SDK_CLK) begin
		ram_addr_o <= word_index_i;
	end

	assign sel_stalled_o = |(core_stall_o & sel);

endmodule

// ==== hw/cmd_bridge_top.sv ====
`timescale 1ns/1ps

module cmd_bridge_top #(
	parameter int NUM_CORES = 8,
	parameter int SETTLE_CYCLES = 20,
	parameter int READ_WAIT_CYCLES = 5,
	parameter int START_HOLD_CYCLES = 30,
	parameter bridge_pkg::core_word_t HALT_PC = '0
) (
	input  logic                                   SDK_CLK,
	input  logic                                   SDK_RSTN,
	input  bridge_pkg::host_word_t                 fifo_di_i,
	input  logic                                   fifo_empty_i,
	input  logic                                   fifo_full_i,
	input  bridge_pkg::core_word_t                 ram_rdata_i,
	input  bridge_pkg::core_word_t [NUM_CORES-1:0] core_pc_i,
	output logic                                   fifo_rd_o,
	output logic                                   fifo_wr_o,
	output bridge_pkg::host_word_t                 fifo_do_o,
	output logic [NUM_CORES-1:0]                   core_rstn_o,
	output logic [NUM_CORES-1:0]                   core_stall_o,
	output logic [NUM_CORES-1:0]                   ram_we_o,
	output logic [bridge_pkg::ADDR_W-1:0]          ram_addr_o,
	output bridge_pkg::core_word_t                 ram_wdata_o
);
	import bridge_pkg::*;

	logic latch_id;
	logic latch_addr;
	logic latch_size;
	logic latch_hi;
	logic latch_lo;
	logic count_step;
	logic clear;
	logic ram_write;
	logic core_reset;
	logic core_start;
	logic more_data;
	logic sel_stalled;
	host_word_t core_id;
	logic [ADDR_W-1:0] word_index;

	frame_sequencer #(
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.READ_WAIT_CYCLES(READ_WAIT_CYCLES),
		.START_HOLD_CYCLES(START_HOLD_CYCLES),
		.NUM_CORES(NUM_CORES)
	) frame_sequencer_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_di_i(fifo_di_i),
		.fifo_empty_i(fifo_empty_i),
		.fifo_full_i(fifo_full_i),
		.ram_rdata_i(ram_rdata_i),
		.core_id_i(core_id),
		.more_data_i(more_data),
		.sel_stalled_i(sel_stalled),
		.fifo_rd_o(fifo_rd_o),
		.fifo_wr_o(fifo_wr_o),
		.fifo_do_o(fifo_do_o),
		.latch_id_o(latch_id),
		.latch_addr_o(latch_addr),
		.latch_size_o(latch_size),
		.latch_hi_o(latch_hi),
		.latch_lo_o(latch_lo),
		.count_step_o(count_step),
		.clear_o(clear),
		.ram_write_o(ram_write),
		.core_reset_o(core_reset),
		.core_start_o(core_start)
	);

	frame_fields frame_fields_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_di_i(fifo_di_i),
		.latch_id_i(latch_id),
		.latch_addr_i(latch_addr),
		.latch_size_i(latch_size),
		.latch_hi_i(latch_hi),
		.latch_lo_i(latch_lo),
		.count_step_i(count_step),
		.clear_i(clear),
		.core_id_o(core_id),
		.word_index_o(word_index),
		.ram_wdata_o(ram_wdata_o),
		.more_data_o(more_data)
	);

	core_control #(
		.NUM_CORES(NUM_CORES),
		.HALT_PC(HALT_PC)
	) core_control_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.core_pc_i(core_pc_i),
		.core_id_i(core_id),
		.word_index_i(word_index),
		.ram_write_i(ram_write),
		.core_reset_i(core_reset),
		.core_start_i(core_start),
		.core_stall_o(core_stall_o),
		.core_rstn_o(core_rstn_o),
		.ram_we_o(ram_we_o),
		.ram_addr_o(ram_addr_o),
		.sel_stalled_o(sel_stalled)
	);

endmodule

// ==== testbench/tb_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_cmd_bridge;
	import bridge_pkg::*;

	localparam int NUM_CORES = 8;
	localparam int SETTLE_CYCLES = 20;
	localparam int READ_WAIT_CYCLES = 5;
	localparam int START_HOLD_CYCLES = 30;
	localparam core_word_t HALT_PC = '0;
	localparam int RAM_DEPTH = 256;
	localparam int STALL_HOLD = 40;
	// Host words over all frames of the run
	localparam int TOTAL_WORDS = 45;
	localparam int CYCLE_LIMIT = 2 * (TOTAL_WORDS * (SETTLE_CYCLES + READ_WAIT_CYCLES + 8)
		+ START_HOLD_CYCLES) + STALL_HOLD + 100;

	logic SDK_CLK;
	logic SDK_RSTN;
	host_word_t fifo_di;
	logic fifo_empty;
	logic fifo_full;
	core_word_t ram_rdata;
	core_word_t [NUM_CORES-1:0] core_pc;
	logic fifo_rd;
	logic fifo_wr;
	host_word_t fifo_do;
	logic [NUM_CORES-1:0] core_rstn;
	logic [NUM_CORES-1:0] core_stall;
	logic [NUM_CORES-1:0] ram_we;
	logic [ADDR_W-1:0] ram_addr;
	core_word_t ram_wdata;

	host_word_t in_q[$];
	host_word_t exp_out[$];
	host_word_t frame_q[$];
	core_word_t ram [NUM_CORES][RAM_DEPTH];
	core_word_t exp_ram [NUM_CORES][RAM_DEPTH];
	int we_cnt [NUM_CORES];
	int exp_we [NUM_CORES];
	int rstn_low_cnt [NUM_CORES];
	int exp_rstn_low [NUM_CORES];
	logic [NUM_CORES-1:0] restart;
	logic [NUM_CORES-1:0] stall_exp;
	logic rd_seen;
	logic full_seen;
	int rd_core;
	int checks;
	int errors;
	int cycle_cnt;
	integer seed;

	cmd_bridge_top #(
		.NUM_CORES(NUM_CORES),
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.READ_WAIT_CYCLES(READ_WAIT_CYCLES),
		.START_HOLD_CYCLES(START_HOLD_CYCLES),
		.HALT_PC(HALT_PC)
	) cmd_bridge_top_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_di_i(fifo_di),
		.fifo_empty_i(fifo_empty),
		.fifo_full_i(fifo_full),
		.ram_rdata_i(ram_rdata),
		.core_pc_i(core_pc),
		.fifo_rd_o(fifo_rd),
		.fifo_wr_o(fifo_wr),
		.fifo_do_o(fifo_do),
		.core_rstn_o(core_rstn),
		.core_stall_o(core_stall),
		.ram_we_o(ram_we),
		.ram_addr_o(ram_addr),
		.ram_wdata_o(ram_wdata)
	);

	always #4 SDK_CLK = ~SDK_CLK;

	// Read port of the RAM that the current frame addresses
	assign ram_rdata = ram[rd_core][ram_addr[7:0]];

	function automatic core_word_t fill_word(input int c, input int a);
		return {8'(8'hC0 + c), 8'h5A, 8'(a), ~8'(a)};
	endfunction

	// Expected RAM, write counts, reset pulses and output words of one frame
	function automatic void model_frame();
		int core;
		int base;
		int words;
		core_word_t w;
		if (frame_q.size() < 3 || frame_q[0] != FRAME_SYNC || frame_q[1] >= NUM_CORES) begin
			return;
		end
		core = frame_q[1];
		if (frame_q[2] == CMD_START) begin
			exp_rstn_low[core]++;
			return;
		end
		base = frame_q[3];
		words = frame_q[4] / 4;
		for (int k = 0; k < words; k++) begin
			if (frame_q[2] == CMD_WRITE) begin
				exp_ram[core][base + k] = {frame_q[5 + 2 * k], frame_q[6 + 2 * k]};
				exp_we[core]++;
			end else begin
				w = exp_ram[core][base + k];
				exp_out.push_back(w[31:16]);
				exp_out.push_back(w[15:0]);
			end
		end
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_models();
		for (int c = 0; c < NUM_CORES; c++) begin
			for (int a = 0; a < RAM_DEPTH; a++) begin
				check($sformatf("ram[%0d][%0d]", c, a), ram[c][a], exp_ram[c][a]);
			end
			check($sformatf("ram_we_o[%0d] pulses", c), we_cnt[c], exp_we[c]);
			check($sformatf("core_rstn_o[%0d] low cycles", c), rstn_low_cnt[c], exp_rstn_low[c]);
		end
	endtask

	task automatic start_frame(input host_word_t w0, input host_word_t w1, input host_word_t w2);
		frame_q.delete();
		frame_q.push_back(w0);
		frame_q.push_back(w1);
		frame_q.push_back(w2);
	endtask

	task automatic add_data(input int n, input int first);
		for (int j = 0; j < n; j++) begin
			frame_q.push_back(host_word_t'(16'h3C00 + (first + j) * 291));
		end
	endtask

	task automatic send_frame();
		@(posedge SDK_CLK);
		model_frame();
		foreach (frame_q[j]) begin
			in_q.push_back(frame_q[j]);
		end
	endtask

	// Sample output FIFO, core RAMs and reset pulses mid-cycle
	always @(negedge SDK_CLK) begin
		rd_seen = fifo_rd;
		if (fifo_wr) begin
			// Write strobe is decided in the cycle before it shows
			if (full_seen) begin
				errors++;
				$display("Output FIFO written after a cycle with fifo_full_i high at %0t", $time);
			end
			if (exp_out.size() == 0) begin
				errors++;
				$display("Unexpected word %h written to the output FIFO at %0t", fifo_do, $time);
			end else begin
				check("fifo_do_o", fifo_do, exp_out.pop_front());
			end
		end
		full_seen = fifo_full;
		for (int i = 0; i < NUM_CORES; i++) begin
			if (ram_we[i]) begin
				ram[i][ram_addr[7:0]] = ram_wdata;
				we_cnt[i]++;
			end
			if (!core_rstn[i]) begin
				rstn_low_cnt[i]++;
				restart[i] = 1'b1;
			end
		end
	end

	// Input FIFO pops one cycle after the strobe
	always @(posedge SDK_CLK) begin
		#1;
		if (rd_seen) begin
			if (in_q.size() == 0) begin
				errors++;
				$display("Read strobe while the input FIFO was empty at %0t", $time);
			end else begin
				fifo_di = in_q.pop_front();
			end
			rd_seen = 1'b0;
		end
		fifo_empty = (in_q.size() == 0);
		fifo_full = (($random(seed) & 3) == 0);
		// A restarted core leaves HALT_PC
		for (int i = 0; i < NUM_CORES; i++) begin
			if (restart[i]) begin
				core_pc[i] = 32'h100 + i;
				restart[i] = 1'b0;
			end
		end
	end

	always @(posedge SDK_CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the bridge did not finish", cycle_cnt);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		SDK_CLK = 1'b0;
		SDK_RSTN = 1'b0;
		fifo_di = '0;
		fifo_empty = 1'b1;
		fifo_full = 1'b0;
		core_pc = '0;
		for (int c = 0; c < NUM_CORES; c++) begin
			core_pc[c] = HALT_PC;
			we_cnt[c] = 0;
			exp_we[c] = 0;
			rstn_low_cnt[c] = 0;
			exp_rstn_low[c] = 0;
			for (int a = 0; a < RAM_DEPTH; a++) begin
				ram[c][a] = fill_word(c, a);
				exp_ram[c][a] = fill_word(c, a);
			end
		end
		restart = '0;
		rd_seen = 1'b0;
		full_seen = 1'b0;
		rd_core = 0;
		checks = 0;
		errors = 0;
		cycle_cnt = 0;
		seed = 32'h5f18_4975;
		repeat (10) @(posedge SDK_CLK);
		#1;
		SDK_RSTN = 1'b1;
		repeat (3) @(posedge SDK_CLK);

		// Four words into core 3
		start_frame(FRAME_SYNC, 16'd3, CMD_WRITE);
		frame_q.push_back(16'h0020);
		frame_q.push_back(16'd16);
		add_data(8, 0);
		send_frame();
		while (we_cnt[3] != exp_we[3]) @(negedge SDK_CLK);
		compare_models();

		// Read back across the written block and its neighbours
		rd_core = 3;
		start_frame(FRAME_SYNC, 16'd3, CMD_READ);
		frame_q.push_back(16'h001E);
		frame_q.push_back(16'd24);
		send_frame();
		while (exp_out.size() != 0) @(negedge SDK_CLK);

		start_frame(FRAME_SYNC, 16'd5, CMD_START);
		send_frame();
		while (core_stall[5] !== 1'b0) @(negedge SDK_CLK);
		stall_exp = '1;
		stall_exp[5] = 1'b0;
		check("core_stall_o", core_stall, stall_exp);
		compare_models();

		// Core 5 runs and the write waits for its halt
		start_frame(FRAME_SYNC, 16'd5, CMD_WRITE);
		frame_q.push_back(16'h0040);
		frame_q.push_back(16'd8);
		add_data(4, 8);
		send_frame();
		while (in_q.size() > 7) @(negedge SDK_CLK);
		repeat (STALL_HOLD) @(negedge SDK_CLK);
		check("ram_we_o[5] pulses", we_cnt[5], 0);
		check("input FIFO level", in_q.size(), 7);
		@(posedge SDK_CLK);
		#1;
		core_pc[5] = HALT_PC;
		while (core_stall[5] !== 1'b1) @(negedge SDK_CLK);
		stall_exp = '1;
		check("core_stall_o", core_stall, stall_exp);
		while (we_cnt[5] != exp_we[5]) @(negedge SDK_CLK);
		compare_models();

		// Bad sync, then an id out of range, then a valid read
		start_frame(16'h1234, 16'd3, CMD_WRITE);
		send_frame();
		start_frame(FRAME_SYNC, 16'(NUM_CORES), CMD_WRITE);
		frame_q.push_back(16'h0010);
		frame_q.push_back(16'd4);
		frame_q.push_back(16'hDEAD);
		frame_q.push_back(16'hBEEF);
		send_frame();
		rd_core = 5;
		start_frame(FRAME_SYNC, 16'd5, CMD_READ);
		frame_q.push_back(16'h0040);
		frame_q.push_back(16'd8);
		send_frame();
		while (exp_out.size() != 0) @(negedge SDK_CLK);
		repeat (10) @(negedge SDK_CLK);
		compare_models();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== Bender.yml ====
package:
  name: cmd_bridge

sources:
  - hw/bridge_pkg.sv
  - hw/frame_sequencer.sv
  - hw/frame_fields.sv
  - hw/core_control.sv
  - hw/cmd_bridge_top.sv
  - target: simulation
    files:
      - testbench/tb_cmd_bridge.sv

// ==== tb.f ====
hw/bridge_pkg.sv
hw/frame_sequencer.sv
hw/frame_fields.sv
hw/core_control.sv
hw/cmd_bridge_top.sv
testbench/tb_cmd_bridge.sv
